/* project.f */
common/pkg_memory.sv
common/pkg_engine.sv
engine_read_write/engine_read_write_kernel.sv
engine_read_write/engine_read_write_ctrl.sv
logic/memory_arbiter.sv
logic/scratch_memory.sv
logic/engine_cluster_top.sv
sim/tb_clock_gen.sv
sim/tb_engine_cluster.sv

/* Bender.yml */
package:
  name: engine_cluster

sources:
  - common/pkg_memory.sv
  - common/pkg_engine.sv
  - engine_read_write/engine_read_write_kernel.sv
  - engine_read_write/engine_read_write_ctrl.sv
  - logic/memory_arbiter.sv
  - logic/scratch_memory.sv
  - logic/engine_cluster_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_engine_cluster.sv

/* sim/tb_engine_cluster.sv */
// Directed tests for the two-engine cluster against a model memory
// Reads are only issued to addresses the model has seen written

`timescale 1ns/1ns

module tb_engine_cluster;

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 16;
  localparam int NUM_TRANSACTIONS = 50;
  localparam int ACK_TIMEOUT      = 40;
  localparam int WATCHDOG_NS      = (NUM_TRANSACTIONS * 40 + RESET_CYCLES) * CLK_PERIOD;

  logic                                                  ap_clk;
  logic                                                  areset;
  logic                     [pkg_engine::NUM_ENGINES-1:0] pkt_req;
  pkg_memory::packet_data_t [pkg_engine::NUM_ENGINES-1:0] pkt_data;
  logic                     [pkg_engine::NUM_ENGINES-1:0] pkt_ack;
  pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] rsp_data;
  pkg_engine::rw_cmd_e      [pkg_engine::NUM_ENGINES-1:0] cfg_cmd;
  pkg_engine::field_mask_t  [pkg_engine::NUM_ENGINES-1:0] cfg_const_mask;
  pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] cfg_const_value;
  pkg_engine::ops_mask_t    [pkg_engine::NUM_ENGINES-1:0] cfg_ops_mask;
  pkg_engine::shift_t       [pkg_engine::NUM_ENGINES-1:0] cfg_granularity;
  logic                     [pkg_engine::NUM_ENGINES-1:0] cfg_direction;
  pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] cfg_array_pointer;
  pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] cfg_index_start;

  // Model memory and which words it knows
  pkg_memory::field_t model_mem   [pkg_memory::MEM_DEPTH];
  logic               model_known [pkg_memory::MEM_DEPTH];

  int error_count;
  int check_count;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .ap_clk (ap_clk),
    .areset (areset)
  );

  engine_cluster_top dut (
    .ap_clk            (ap_clk),
    .areset            (areset),
    .pkt_req           (pkt_req),
    .pkt_data          (pkt_data),
    .pkt_ack           (pkt_ack),
    .rsp_data          (rsp_data),
    .cfg_cmd           (cfg_cmd),
    .cfg_const_mask    (cfg_const_mask),
    .cfg_const_value   (cfg_const_value),
    .cfg_ops_mask      (cfg_ops_mask),
    .cfg_granularity   (cfg_granularity),
    .cfg_direction     (cfg_direction),
    .cfg_array_pointer (cfg_array_pointer),
    .cfg_index_start   (cfg_index_start)
  );

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  function automatic pkg_memory::packet_data_t make_packet(
    input pkg_memory::field_t f0, input pkg_memory::field_t f1,
    input pkg_memory::field_t f2, input pkg_memory::field_t f3);
    return {f3, f2, f1, f0};
  endfunction

  // Data field named by a one-hot row of the ops mask
  function automatic pkg_memory::field_t pick_source(
    input pkg_memory::packet_data_t pkt, input logic [3:0] row);
    pkg_memory::field_t word;
    word = '0;
    for (int j = 0; j < 4; j++) begin
      if (row[j]) word = pkt[j*32 +: 32];
    end
    return word;
  endfunction

  // Ops field 1 plus index, shifted, plus pointer, low 8 bits
  function automatic pkg_memory::mem_addr_t expected_address(
    input int eng, input pkg_memory::packet_data_t pkt);
    pkg_memory::field_t offset;
    pkg_memory::field_t moved;
    pkg_memory::field_t total;
    if (cfg_const_mask[eng][1]) offset = cfg_const_value[eng];
    else offset = pick_source(pkt, cfg_ops_mask[eng][7:4]);
    offset = offset + cfg_index_start[eng];
    if (cfg_direction[eng]) moved = offset << cfg_granularity[eng];
    else moved = offset >> cfg_granularity[eng];
    total = moved + cfg_array_pointer[eng];
    return total[7:0];
  endfunction

  task automatic check_word(input string name, input pkg_memory::field_t got,
                            input pkg_memory::field_t exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("MISMATCH t=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic set_config(input int eng, input pkg_engine::field_mask_t cmask,
                            input pkg_memory::field_t cval, input pkg_engine::ops_mask_t omask,
                            input pkg_engine::shift_t gran, input logic dir,
                            input pkg_memory::field_t ptr, input pkg_memory::field_t idx);
    @(posedge ap_clk);
    #2;
    cfg_const_mask[eng]    = cmask;
    cfg_const_value[eng]   = cval;
    cfg_ops_mask[eng]      = omask;
    cfg_granularity[eng]   = gran;
    cfg_direction[eng]     = dir;
    cfg_array_pointer[eng] = ptr;
    cfg_index_start[eng]   = idx;
  endtask

  // ----------------------------------------------------------
  // One four-phase packet transaction with model check
  // ----------------------------------------------------------

  task automatic do_packet(input int eng, input pkg_engine::rw_cmd_e cmd,
                           input pkg_memory::packet_data_t pkt,
                           output pkg_memory::field_t rsp);
    pkg_memory::mem_addr_t addr;
    pkg_memory::field_t    word;
    int                    cycles;
    addr = expected_address(eng, pkt);
    word = pick_source(pkt, cfg_ops_mask[eng][3:0]);
    rsp = '0;
    @(posedge ap_clk);
    #2;
    cfg_cmd[eng]  = cmd;
    pkt_data[eng] = pkt;
    pkt_req[eng]  = 1'b1;
    cycles = 0;
    do begin
      @(posedge ap_clk);
      #2;
      cycles++;
    end while (!pkt_ack[eng] && cycles < ACK_TIMEOUT);
    assert (pkt_ack[eng]) else begin
      error_count++;
      $display("Engine %0d gave no pkt_ack within %0d cycles", eng, ACK_TIMEOUT);
    end
    if (pkt_ack[eng]) begin
      rsp = rsp_data[eng];
      if (cmd == pkg_engine::CMD_WRITE) begin
        model_mem[addr]   = word;
        model_known[addr] = 1'b1;
        check_word($sformatf("rsp_data[%0d]", eng), rsp, '0);
      end else begin
        assert (model_known[addr]) else begin
          error_count++;
          $display("Engine %0d read address %h that was never written", eng, addr);
        end
        if (model_known[addr]) check_word($sformatf("rsp_data[%0d]", eng), rsp, model_mem[addr]);
      end
    end
    pkt_req[eng] = 1'b0;
    cycles = 0;
    while (pkt_ack[eng] && cycles < ACK_TIMEOUT) begin
      @(posedge ap_clk);
      #2;
      cycles++;
    end
    assert (!pkt_ack[eng]) else begin
      error_count++;
      $display("Engine %0d kept pkt_ack high after pkt_req fell", eng);
    end
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------

  task automatic reset_state();
    for (int e = 0; e < pkg_engine::NUM_ENGINES; e++) begin
      check_word($sformatf("pkt_ack[%0d]", e), 32'(pkt_ack[e]), '0);
    end
  endtask

  task automatic write_then_read();
    pkg_memory::packet_data_t pkt;
    pkg_memory::field_t       rsp;
    set_config(0, 4'b0000, '0, 16'h8421, 5'd2, 1'b1, $urandom, $urandom % 64);
    pkt = make_packet($urandom, $urandom, $urandom, $urandom);
    do_packet(0, pkg_engine::CMD_WRITE, pkt, rsp);
    // Same field 1, fresh other fields
    pkt = make_packet($urandom, pkt[63:32], $urandom, $urandom);
    do_packet(0, pkg_engine::CMD_READ, pkt, rsp);
  endtask

  task automatic const_insertion();
    pkg_memory::packet_data_t pkt;
    pkg_memory::field_t       f0;
    pkg_memory::field_t       rsp;
    f0 = $urandom | 32'h8000_0000;
    // Constant on ops fields 0 and 1, the write word stays data field 0
    set_config(0, 4'b0011, 32'h11, 16'h8421, 5'd1, 1'b1, 32'h20, 32'd3);
    pkt = make_packet(f0, $urandom, $urandom, $urandom);
    do_packet(0, pkg_engine::CMD_WRITE, pkt, rsp);
    // Plain data field 1 equal to the constant reaches the same word
    set_config(0, 4'b0000, '0, 16'h8421, 5'd1, 1'b1, 32'h20, 32'd3);
    pkt = make_packet($urandom, 32'h11, $urandom, $urandom);
    do_packet(0, pkg_engine::CMD_READ, pkt, rsp);
    check_word("const read-back", rsp, f0);
  endtask

  task automatic right_shift_permutation();
    pkg_memory::packet_data_t pkt;
    pkg_memory::field_t       f3;
    pkg_memory::field_t       rsp;
    f3 = $urandom;
    // Row 0 takes field 3, row 1 takes field 2
    set_config(1, 4'b0000, '0, 16'h1248, 5'd3, 1'b0, 32'h90, 32'd5);
    pkt = make_packet($urandom, $urandom, $urandom, f3);
    do_packet(1, pkg_engine::CMD_WRITE, pkt, rsp);
    pkt = make_packet($urandom, $urandom, pkt[95:64], $urandom);
    do_packet(1, pkg_engine::CMD_READ, pkt, rsp);
    check_word("permuted read-back", rsp, f3);
  endtask

  task automatic engine_contention();
    pkg_memory::packet_data_t pkt0;
    pkg_memory::packet_data_t pkt1;
    pkg_memory::field_t       rsp0;
    pkg_memory::field_t       rsp1;
    set_config(0, 4'b0000, '0, 16'h8421, 5'd0, 1'b1, 32'h40, 32'd0);
    set_config(1, 4'b0000, '0, 16'h8421, 5'd0, 1'b1, 32'h80, 32'd0);
    pkt0 = make_packet($urandom, 32'h7, $urandom, $urandom);
    pkt1 = make_packet($urandom, 32'h7, $urandom, $urandom);
    fork
      do_packet(0, pkg_engine::CMD_WRITE, pkt0, rsp0);
      do_packet(1, pkg_engine::CMD_WRITE, pkt1, rsp1);
    join
    do_packet(0, pkg_engine::CMD_READ, pkt0, rsp0);
    do_packet(1, pkg_engine::CMD_READ, pkt1, rsp1);
  endtask

  task automatic random_sweep();
    pkg_memory::packet_data_t pkt;
    pkg_memory::field_t       rsp;
    pkg_engine::ops_mask_t    omask;
    pkg_engine::field_mask_t  cmask;
    pkg_memory::field_t       cval;
    pkg_memory::field_t       ptr;
    pkg_memory::field_t       idx;
    pkg_engine::shift_t       gran;
    logic                     dir;
    int                       wr_eng;
    int                       rd_eng;
    pkg_memory::mem_addr_t    wr_addr;
    for (int n = 0; n < 20; n++) begin
      omask = '0;
      for (int r = 0; r < 4; r++) omask[r*4 + ($urandom % 4)] = 1'b1;
      cmask  = pkg_engine::field_mask_t'($urandom);
      cval   = $urandom;
      ptr    = $urandom;
      idx    = $urandom;
      gran   = pkg_engine::shift_t'($urandom % 8);
      dir    = 1'($urandom);
      wr_eng = $urandom % 2;
      rd_eng = $urandom % 2;
      set_config(0, cmask, cval, omask, gran, dir, ptr, idx);
      set_config(1, cmask, cval, omask, gran, dir, ptr, idx);
      pkt = make_packet($urandom, $urandom, $urandom, $urandom);
      do_packet(wr_eng, pkg_engine::CMD_WRITE, pkt, rsp);
      // Read back through the constant, which names the model address directly
      wr_addr = expected_address(wr_eng, pkt);
      set_config(rd_eng, 4'b0010, 32'(wr_addr), omask, 5'd0, 1'b1, '0, '0);
      do_packet(rd_eng, pkg_engine::CMD_READ, pkt, rsp);
    end
  endtask

  // ----------------------------------------------------------
  // Run control
  // ----------------------------------------------------------

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(32'h19b8));
    error_count = 0;
    check_count = 0;
    pkt_req     = '0;
    pkt_data    = '0;
    for (int e = 0; e < pkg_engine::NUM_ENGINES; e++) begin
      cfg_cmd[e] = pkg_engine::CMD_READ;
    end
    cfg_const_mask    = '0;
    cfg_const_value   = '0;
    cfg_ops_mask      = '0;
    cfg_granularity   = '0;
    cfg_direction     = '0;
    cfg_array_pointer = '0;
    cfg_index_start   = '0;
    for (int a = 0; a < pkg_memory::MEM_DEPTH; a++) begin
      model_known[a] = 1'b0;
    end
    @(posedge ap_clk);
    while (areset) @(posedge ap_clk);
    #2;
    reset_state();
    write_then_read();
    const_insertion();
    right_shift_permutation();
    engine_contention();
    random_sweep();
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
// Free-running testbench clock and a synchronous active-high reset
// Reset drops a short delay after the last reset edge, in step with the stimulus

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic ap_clk,
  output logic areset
);

  initial begin
    ap_clk = 1'b0;
    forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
  end

  initial begin
    areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #2;
    areset = 1'b0;
  end

endmodule

/* logic/engine_cluster_top.sv */
// Two read/write engines sharing one scratch memory through a round-robin arbiter
// Per-engine ports are packed arrays indexed by engine number

`timescale 1ns/1ns

module engine_cluster_top (
  input  logic                     ap_clk,
  input  logic                     areset,
  input  logic                     [pkg_engine::NUM_ENGINES-1:0] pkt_req,
  input  pkg_memory::packet_data_t [pkg_engine::NUM_ENGINES-1:0] pkt_data,
  output logic                     [pkg_engine::NUM_ENGINES-1:0] pkt_ack,
  output pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] rsp_data,
  input  pkg_engine::rw_cmd_e      [pkg_engine::NUM_ENGINES-1:0] cfg_cmd,
  input  pkg_engine::field_mask_t  [pkg_engine::NUM_ENGINES-1:0] cfg_const_mask,
  input  pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] cfg_const_value,
  input  pkg_engine::ops_mask_t    [pkg_engine::NUM_ENGINES-1:0] cfg_ops_mask,
  input  pkg_engine::shift_t       [pkg_engine::NUM_ENGINES-1:0] cfg_granularity,
  input  logic                     [pkg_engine::NUM_ENGINES-1:0] cfg_direction,
  input  pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] cfg_array_pointer,
  input  pkg_memory::field_t       [pkg_engine::NUM_ENGINES-1:0] cfg_index_start
);

  // Engine side of the arbiter
  logic                  [pkg_engine::NUM_ENGINES-1:0] eng_req;
  logic                  [pkg_engine::NUM_ENGINES-1:0] eng_we;
  pkg_memory::mem_addr_t [pkg_engine::NUM_ENGINES-1:0] eng_addr;
  pkg_memory::field_t    [pkg_engine::NUM_ENGINES-1:0] eng_wdata;
  logic                  [pkg_engine::NUM_ENGINES-1:0] eng_ack;
  pkg_memory::field_t                                  eng_rdata;

  // Memory side of the arbiter
  logic                  mem_req;
  logic                  mem_we;
  pkg_memory::mem_addr_t mem_addr;
  pkg_memory::field_t    mem_wdata;
  logic                  mem_ack;
  pkg_memory::field_t    mem_rdata;

  for (genvar e = 0; e < pkg_engine::NUM_ENGINES; e++) begin : g_engine
    engine_read_write_ctrl u_engine (
      .ap_clk            (ap_clk),
      .areset            (areset),
      .pkt_req           (pkt_req[e]),
      .pkt_data          (pkt_data[e]),
      .cfg_cmd           (cfg_cmd[e]),
      .cfg_const_mask    (cfg_const_mask[e]),
      .cfg_const_value   (cfg_const_value[e]),
      .cfg_ops_mask      (cfg_ops_mask[e]),
      .cfg_granularity   (cfg_granularity[e]),
      .cfg_direction     (cfg_direction[e]),
      .cfg_array_pointer (cfg_array_pointer[e]),
      .cfg_index_start   (cfg_index_start[e]),
      .pkt_ack           (pkt_ack[e]),
      .rsp_data          (rsp_data[e]),
      .mem_req           (eng_req[e]),
      .mem_we            (eng_we[e]),
      .mem_addr          (eng_addr[e]),
      .mem_wdata         (eng_wdata[e]),
      .mem_ack           (eng_ack[e]),
      .mem_rdata         (eng_rdata)
    );
  end

  memory_arbiter u_arbiter (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .eng_req   (eng_req),
    .eng_we    (eng_we),
    .eng_addr  (eng_addr),
    .eng_wdata (eng_wdata),
    .eng_ack   (eng_ack),
    .eng_rdata (eng_rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  scratch_memory u_memory (
    .ap_clk (ap_clk),
    .areset (areset),
    .req    (mem_req),
    .we     (mem_we),
    .addr   (mem_addr),
    .wdata  (mem_wdata),
    .ack    (mem_ack),
    .rdata  (mem_rdata)
  );

endmodule

/* logic/scratch_memory.sv */
// Word-addressed scratch memory, one access per four-phase handshake
// Contents are not cleared by reset

`timescale 1ns/1ns

module scratch_memory (
  input  logic                  ap_clk,
  input  logic                  areset,
  input  logic                  req,
  input  logic                  we,
  input  pkg_memory::mem_addr_t addr,
  input  pkg_memory::field_t    wdata,
  output logic                  ack,
  output pkg_memory::field_t    rdata
);

  pkg_memory::field_t mem_array [pkg_memory::MEM_DEPTH];
  logic               access;

  // The access happens on the cycle that raises ack
  assign access = req && !ack;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ack <= 1'b0;
    end else if (access) begin
      ack <= 1'b1;
    end else if (!req) begin
      ack <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (access) begin
      if (we) begin
        mem_array[addr] <= wdata;
      end else begin
        rdata <= mem_array[addr];
      end
    end
  end

  // A request is only withdrawn after it was acknowledged
  assert property (@(posedge ap_clk) disable iff (areset) $fell(req) |-> $past(ack));

endmodule

/* logic/memory_arbiter.sv */
// Round-robin grant for the shared memory port, one transaction at a time
// A grant is held until the engine request and the memory ack have both fallen

`timescale 1ns/1ns

module memory_arbiter (
  input  logic                                                 ap_clk,
  input  logic                                                 areset,
  input  logic                  [pkg_engine::NUM_ENGINES-1:0]  eng_req,
  input  logic                  [pkg_engine::NUM_ENGINES-1:0]  eng_we,
  input  pkg_memory::mem_addr_t [pkg_engine::NUM_ENGINES-1:0]  eng_addr,
  input  pkg_memory::field_t    [pkg_engine::NUM_ENGINES-1:0]  eng_wdata,
  output logic                  [pkg_engine::NUM_ENGINES-1:0]  eng_ack,
  output pkg_memory::field_t                                   eng_rdata,
  output logic                                                 mem_req,
  output logic                                                 mem_we,
  output pkg_memory::mem_addr_t                                mem_addr,
  output pkg_memory::field_t                                   mem_wdata,
  input  logic                                                 mem_ack,
  input  pkg_memory::field_t                                   mem_rdata
);

  logic [pkg_engine::NUM_ENGINES-1:0] grant_q;
  pkg_engine::engine_idx_t            last_q;
  pkg_engine::engine_idx_t            next_idx;
  logic                               next_found;

  // Search starts one past the last winner
  always_comb begin
    next_idx   = last_q;
    next_found = 1'b0;
    for (int k = 1; k <= pkg_engine::NUM_ENGINES; k++) begin
      if (!next_found && eng_req[(int'(last_q) + k) % pkg_engine::NUM_ENGINES]) begin
        next_idx   = pkg_engine::engine_idx_t'((int'(last_q) + k) % pkg_engine::NUM_ENGINES);
        next_found = 1'b1;
      end
    end
  end

  // last_q doubles as the index of the active grant
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      grant_q <= '0;
      last_q  <= '0;
    end else if (grant_q == '0) begin
      if (next_found) begin
        grant_q           <= '0;
        grant_q[next_idx] <= 1'b1;
        last_q            <= next_idx;
      end
    end else if (!eng_req[last_q] && !mem_ack) begin
      grant_q <= '0;
    end
  end

  // ----------------------------------------------------------
  // Pass the granted handshake through
  // ----------------------------------------------------------

  assign mem_req   = (|grant_q) & eng_req[last_q];
  assign mem_we    = eng_we[last_q];
  assign mem_addr  = eng_addr[last_q];
  assign mem_wdata = eng_wdata[last_q];

  assign eng_ack   = grant_q & {pkg_engine::NUM_ENGINES{mem_ack}};
  assign eng_rdata = mem_rdata;

  assert property (@(posedge ap_clk) disable iff (areset) $onehot0(grant_q));

endmodule

/* engine_read_write/engine_read_write_ctrl.sv */
// One packet in flight per engine, the next pkt_req only after pkt_ack is low
// pkt_data and the cfg inputs must stay stable until pkt_ack rises

`timescale 1ns/1ns

module engine_read_write_ctrl (
  input  logic                      ap_clk,
  input  logic                      areset,
  input  logic                      pkt_req,
  input  pkg_memory::packet_data_t  pkt_data,
  input  pkg_engine::rw_cmd_e       cfg_cmd,
  input  pkg_engine::field_mask_t   cfg_const_mask,
  input  pkg_memory::field_t        cfg_const_value,
  input  pkg_engine::ops_mask_t     cfg_ops_mask,
  input  pkg_engine::shift_t        cfg_granularity,
  input  logic                      cfg_direction,
  input  pkg_memory::field_t        cfg_array_pointer,
  input  pkg_memory::field_t        cfg_index_start,
  output logic                      pkt_ack,
  output pkg_memory::field_t        rsp_data,
  output logic                      mem_req,
  output logic                      mem_we,
  output pkg_memory::mem_addr_t     mem_addr,
  output pkg_memory::field_t        mem_wdata,
  input  logic                      mem_ack,
  input  pkg_memory::field_t        mem_rdata
);

  pkg_engine::ctrl_state_e  state_q;
  logic                     kern_valid;
  logic                     kern_valid_out;
  pkg_memory::mem_addr_t    kern_addr;
  pkg_memory::packet_data_t kern_result;

  // In ST_IDLE pkt_ack is already low, so a high pkt_req is a new request
  assign kern_valid = (state_q == pkg_engine::ST_IDLE) && pkt_req;

  engine_read_write_kernel u_kernel (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .data_valid    (kern_valid),
    .data          (pkt_data),
    .const_mask    (cfg_const_mask),
    .const_value   (cfg_const_value),
    .ops_mask      (cfg_ops_mask),
    .granularity   (cfg_granularity),
    .direction     (cfg_direction),
    .array_pointer (cfg_array_pointer),
    .index_start   (cfg_index_start),
    .valid_out     (kern_valid_out),
    .address_out   (kern_addr),
    .result_out    (kern_result)
  );

  // ----------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state_q <= pkg_engine::ST_IDLE;
      mem_req <= 1'b0;
      pkt_ack <= 1'b0;
    end else begin
      case (state_q)
        pkg_engine::ST_IDLE: begin
          if (pkt_req) state_q <= pkg_engine::ST_KERNEL;
        end
        pkg_engine::ST_KERNEL: begin
          if (kern_valid_out) begin
            mem_req <= 1'b1;
            state_q <= pkg_engine::ST_MEM;
          end
        end
        pkg_engine::ST_MEM: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            pkt_ack <= 1'b1;
            state_q <= pkg_engine::ST_DONE;
          end
        end
        pkg_engine::ST_DONE: begin
          // Both handshakes must be closed before the next packet
          if (!pkt_req && !mem_ack) begin
            pkt_ack <= 1'b0;
            state_q <= pkg_engine::ST_IDLE;
          end
        end
        default: state_q <= pkg_engine::ST_IDLE;
      endcase
    end
  end

  // Memory request fields and the response word
  always_ff @(posedge ap_clk) begin
    if (state_q == pkg_engine::ST_KERNEL && kern_valid_out) begin
      mem_addr  <= kern_addr;
      mem_wdata <= kern_result[pkg_memory::FIELD_W-1:0];
      mem_we    <= (cfg_cmd == pkg_engine::CMD_WRITE);
    end
    if (state_q == pkg_engine::ST_MEM && mem_ack) begin
      rsp_data <= mem_we ? '0 : mem_rdata;
    end
  end

  // Request fields hold for the whole memory handshake
  assert property (@(posedge ap_clk) disable iff (areset)
    mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we));

endmodule

/* engine_read_write/engine_read_write_kernel.sv */
// Two-stage kernel that accepts one item per cycle with no stall input
// Configuration inputs are sampled in both stages and must be held for the item
// Address offset comes from ops field 1, the write word from original field 0

`timescale 1ns/1ns

module engine_read_write_kernel (
  input  logic                      ap_clk,
  input  logic                      areset,
  input  logic                      data_valid,
  input  pkg_memory::packet_data_t  data,
  input  pkg_engine::field_mask_t   const_mask,
  input  pkg_memory::field_t        const_value,
  input  pkg_engine::ops_mask_t     ops_mask,
  input  pkg_engine::shift_t        granularity,
  input  logic                      direction,
  input  pkg_memory::field_t        array_pointer,
  input  pkg_memory::field_t        index_start,
  output logic                      valid_out,
  output pkg_memory::mem_addr_t     address_out,
  output pkg_memory::packet_data_t  result_out
);

  pkg_memory::packet_data_t org_perm;
  pkg_memory::packet_data_t ops_perm;
  pkg_memory::packet_data_t org_q;
  pkg_memory::packet_data_t ops_q;
  pkg_memory::field_t       addr_sum;
  pkg_memory::field_t       addr_shift;
  pkg_memory::field_t       addr_full;

  logic [pkg_engine::KERNEL_LATENCY-1:0] valid_pipe;

  // ----------------------------------------------------------
  // Stage 1: permutation and constant insertion
  // ----------------------------------------------------------

  always_comb begin
    org_perm = '0;
    ops_perm = '0;
    for (int i = 0; i < pkg_memory::NUM_FIELDS; i++) begin
      // One-hot select, so at most one source drives each field
      for (int j = 0; j < pkg_memory::NUM_FIELDS; j++) begin
        if (ops_mask[i*pkg_memory::NUM_FIELDS + j]) begin
          org_perm[i*pkg_memory::FIELD_W +: pkg_memory::FIELD_W] =
            data[j*pkg_memory::FIELD_W +: pkg_memory::FIELD_W];
        end
      end
      if (const_mask[i]) begin
        ops_perm[i*pkg_memory::FIELD_W +: pkg_memory::FIELD_W] = const_value;
      end else begin
        ops_perm[i*pkg_memory::FIELD_W +: pkg_memory::FIELD_W] =
          org_perm[i*pkg_memory::FIELD_W +: pkg_memory::FIELD_W];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    org_q <= org_perm;
    ops_q <= ops_perm;
  end

  // ----------------------------------------------------------
  // Stage 2: address computation
  // ----------------------------------------------------------

  always_comb begin
    addr_sum = ops_q[pkg_memory::FIELD_W +: pkg_memory::FIELD_W] + index_start;
    if (direction) begin
      addr_shift = addr_sum << granularity;
    end else begin
      addr_shift = addr_sum >> granularity;
    end
    addr_full = addr_shift + array_pointer;
  end

  always_ff @(posedge ap_clk) begin
    address_out <= addr_full[pkg_memory::MEM_ADDR_W-1:0];
    result_out  <= org_q;
  end

  // Valid travels alongside the two data stages
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[pkg_engine::KERNEL_LATENCY-2:0], data_valid};
    end
  end

  assign valid_out = valid_pipe[pkg_engine::KERNEL_LATENCY-1];

  // Every permutation row picks exactly one source field
  for (genvar r = 0; r < pkg_memory::NUM_FIELDS; r++) begin : g_row_check
    assert property (@(posedge ap_clk) disable iff (areset)
      data_valid |-> $onehot(ops_mask[r*pkg_memory::NUM_FIELDS +: pkg_memory::NUM_FIELDS]));
  end

endmodule

/* common/pkg_engine.sv */
// Engine-side constants, configuration types and state encodings
// Mask widths follow pkg_memory::NUM_FIELDS, so pkg_memory compiles first

package pkg_engine;

  // ----------------------------------------------------------
  // Cluster and pipeline constants
  // ----------------------------------------------------------

  // Read/write engines sharing the scratch memory
  localparam int NUM_ENGINES = 2;

  // Kernel cycles from data_valid to valid_out
  localparam int KERNEL_LATENCY = 2;

  // ----------------------------------------------------------
  // Configuration types
  // ----------------------------------------------------------

  // Bit i replaces ops field i with the constant
  typedef logic [pkg_memory::NUM_FIELDS-1:0] field_mask_t;

  // Row i (bits 4i..4i+3) is a one-hot source select for output field i
  typedef logic [pkg_memory::NUM_FIELDS*pkg_memory::NUM_FIELDS-1:0] ops_mask_t;

  // Address shift amount
  typedef logic [4:0] shift_t;

  // Engine index, used by the arbiter for its last winner
  typedef logic [$clog2(NUM_ENGINES)-1:0] engine_idx_t;

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } rw_cmd_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_KERNEL,
    ST_MEM,
    ST_DONE
  } ctrl_state_e;

endpackage

/* common/pkg_memory.sv */
// Memory-side widths and types shared by the engines, the arbiter and the memory
// A packet is four 32-bit fields, with field i in bits i*32 upward
// The scratch memory is word addressed and MEM_DEPTH must be a power of two

package pkg_memory;

  // ----------------------------------------------------------
  // Packet geometry
  // ----------------------------------------------------------

  // Width of one packet field, also the memory word width
  localparam int FIELD_W = 32;

  // Fields carried by one memory packet
  localparam int NUM_FIELDS = 4;

  // Full packet width
  localparam int PACKET_W = FIELD_W * NUM_FIELDS;

  // ----------------------------------------------------------
  // Scratch memory geometry
  // ----------------------------------------------------------

  // Depth in words
  localparam int MEM_DEPTH = 256;

  // Word address width, follows the depth
  localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------

  // One packet field or one memory word
  typedef logic [FIELD_W-1:0] field_t;

  // Four fields packed low to high
  typedef logic [PACKET_W-1:0] packet_data_t;

  // Word address into the scratch memory
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage
